// ==== files.f ====
+incdir+include
verilog/cpu_pkg.sv
verilog/io_pkg.sv
verilog/mem_bus_if.sv
verilog/ifetch.sv
verilog/decoder.sv
verilog/alu.sv
verilog/mem_or_io.sv
verilog/cpu_top.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then decide from the simulation log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_cpu \
    -Mdir obj_dir -o sim_cpu > build.log 2>&1 &&
./obj_dir/sim_cpu > sim.log 2>&1 &&
! grep -q "Test failures found" sim.log &&
echo "PASS" ||
{ echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== dv/tb_cpu.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module tb_cpu;

    localparam int RUNS          = 8;
    localparam int PROG_WORDS    = 31;
    // 8 runs, a 3 instruction loop of up to 4095 turns, load and margin
    localparam int MAX_CYCLES    = 200000;
    // quiet cycles after the last word, self-loop must keep led_o still
    localparam int SETTLE_CYCLES = 16;

    localparam logic [31:0] IO_BASE_W = `IO_BASE;
    localparam logic [11:0] SW_OFS    = 12'(`IO_SWITCH_ADDR - `IO_BASE);
    localparam logic [11:0] LED_OFS   = 12'(`IO_LED_ADDR - `IO_BASE);
    // scratch word in data memory
    localparam logic [11:0] SCRATCH   = 12'h010;

    logic        clk;
    logic        rst_n;
    logic        prog_en;
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [31:0] prog_data;
    logic [11:0] switches;
    logic [15:0] led;
    logic [3:0]  run_num;
    logic [31:0] lfsr_state;
    logic [31:0] program_mem [PROG_WORDS];
    int          cycle_count = 0;
    int          words_seen;
    int          mismatches;
    int          failures;

    always #5 clk = ~clk;

    cpu_top DUT (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .prog_en_i   (prog_en),
        .prog_we_i   (prog_we),
        .prog_addr_i (prog_addr),
        .prog_data_i (prog_data),
        .switch_i    (switches),
        .led_o       (led)
    );

    cpu_checker u_checker (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .prog_en_i        (prog_en),
        .run_i            (run_num),
        .switch_i         (switches),
        .led_i            (led),
        .words_seen_o     (words_seen),
        .mismatch_count_o (mismatches),
        .error_count_o    (failures)
    );

    // ------------------------------------------------------------------------
    // rv32i encoders
    // ------------------------------------------------------------------------
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // sw only
    function automatic logic [31:0] store_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `OP_LUI};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ------------------------------------------------------------------------
    // test program
    // ------------------------------------------------------------------------
    task automatic build_program();
        // word 1, tag 1 with the switches
        program_mem[0]  = lui_word(5'd1, IO_BASE_W[31:12]);
        program_mem[1]  = i_word(`OP_LOAD, 3'b010, 5'd2, 5'd1, SW_OFS);
        program_mem[2]  = lui_word(5'd3, 20'h1);
        program_mem[3]  = r_word(7'h00, 3'b000, 5'd4, 5'd3, 5'd2);
        program_mem[4]  = store_word(5'd1, 5'd4, LED_OFS);
        // word 2, sum 1..n, beq skips the loop for n of zero
        program_mem[5]  = i_word(`OP_ITYPE, 3'b000, 5'd5, 5'd0, 12'd0);
        program_mem[6]  = i_word(`OP_ITYPE, 3'b000, 5'd6, 5'd0, 12'd0);
        program_mem[7]  = branch_word(3'b000, 5'd2, 5'd0, 13'd16);
        program_mem[8]  = i_word(`OP_ITYPE, 3'b000, 5'd6, 5'd6, 12'd1);
        program_mem[9]  = r_word(7'h00, 3'b000, 5'd5, 5'd5, 5'd6);
        // back by two words to the loop head
        program_mem[10] = branch_word(3'b001, 5'd6, 5'd2, 13'h1ff8);
        program_mem[11] = lui_word(5'd7, 20'h1);
        program_mem[12] = i_word(`OP_ITYPE, 3'b000, 5'd7, 5'd7, 12'hfff);
        program_mem[13] = r_word(7'h00, 3'b111, 5'd5, 5'd5, 5'd7);
        program_mem[14] = lui_word(5'd8, 20'h2);
        program_mem[15] = r_word(7'h00, 3'b110, 5'd9, 5'd5, 5'd8);
        program_mem[16] = store_word(5'd1, 5'd9, LED_OFS);
        // word 3, xor through a data memory round trip
        program_mem[17] = i_word(`OP_ITYPE, 3'b000, 5'd10, 5'd0, 12'h5a5);
        program_mem[18] = r_word(7'h00, 3'b100, 5'd11, 5'd2, 5'd10);
        program_mem[19] = store_word(5'd0, 5'd11, SCRATCH);
        program_mem[20] = i_word(`OP_LOAD, 3'b010, 5'd12, 5'd0, SCRATCH);
        program_mem[21] = lui_word(5'd13, 20'h3);
        program_mem[22] = r_word(7'h00, 3'b110, 5'd14, 5'd12, 5'd13);
        program_mem[23] = store_word(5'd1, 5'd14, LED_OFS);
        // word 4, n below 100 via sub then slt against x0
        program_mem[24] = i_word(`OP_ITYPE, 3'b000, 5'd15, 5'd0, 12'd100);
        program_mem[25] = r_word(7'h20, 3'b000, 5'd16, 5'd2, 5'd15);
        program_mem[26] = r_word(7'h00, 3'b010, 5'd17, 5'd16, 5'd0);
        program_mem[27] = lui_word(5'd18, 20'h4);
        program_mem[28] = r_word(7'h00, 3'b110, 5'd19, 5'd17, 5'd18);
        program_mem[29] = store_word(5'd1, 5'd19, LED_OFS);
        // park
        program_mem[30] = jal_word(5'd0, 21'd0);
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = 8'(i);
            prog_data = program_mem[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
        prog_en = 1'b0;
    endtask

    // one run: new n, reset, load, wait for four words, then stay quiet
    task automatic do_run(input int run);
        logic [11:0] n;
        n = '0;
        for (int b = 0; b < 12; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            n = {n[10:0], lfsr_state[0]};
        end
        @(negedge clk);
        run_num  = 4'(run);
        switches = n;
        rst_n    = 1'b0;
        prog_en  = 1'b1;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        load_program();
        while (words_seen < 4) begin
            @(negedge clk);
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    task automatic print_counts();
        $display("Checks done: %0d mismatches, %0d other errors, %0d cycles",
                 mismatches, failures, cycle_count);
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        prog_en    = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        switches   = '0;
        run_num    = '0;
        lfsr_state = 32'ha461;
        build_program();
        for (int r = 0; r < RUNS; r++) begin
            do_run(r);
        end
        print_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the runs did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("Test failures found");
            $finish;
        end
    end

endmodule

// ==== dv/cpu_checker.sv ====
`timescale 1ns/100ps

module cpu_checker (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        prog_en_i,
    input  logic [3:0]  run_i,
    input  logic [11:0] switch_i,
    input  logic [15:0] led_i,
    output int          words_seen_o,
    output int          mismatch_count_o,
    output int          error_count_o
);

    // per run state
    int          seen       = 0;
    int          mismatches = 0;
    int          failures   = 0;
    logic [15:0] led_prev   = '0;
    logic [63:0] expected;

    // ------------------------------------------------------------------------
    // reference model of the test program
    // ------------------------------------------------------------------------
    // word k of the run sits in bits 16k+15:16k
    function automatic logic [63:0] expected_leds(input logic [11:0] n);
        logic [31:0] sum;
        logic [11:0] flipped;
        logic        below;
        sum = 0;
        // triangular number kept to its low 12 bits
        for (int i = 1; i <= int'(n); i++) begin
            sum = sum + 32'(i);
        end
        flipped = n ^ 12'h5a5;
        below   = (n < 12'd100);
        return {4'h4, 11'b0, below,
                4'h3, flipped,
                4'h2, sum[11:0],
                4'h1, n};
    endfunction

    // ------------------------------------------------------------------------
    // led watcher
    // ------------------------------------------------------------------------
    // led_o is read before the edge updates it
    // inputs have settled since the falling edge
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            seen     = 0;
            led_prev = '0;
        end else if (prog_en_i) begin
            // led must sit at zero while the program goes in
            if (led_i !== 16'h0000) begin
                mismatches++;
                $display("Mismatch at %0t: run %0d program load expected led_o 0000 got %h",
                         $time, run_i, led_i);
            end
        end else if (led_i !== led_prev) begin
            expected = expected_leds(switch_i);
            if (seen >= 4) begin
                // cpu should be parked in the jal self-loop
                failures++;
                $display("Error at %0t: run %0d, led_o changed to %h after the last word",
                         $time, run_i, led_i);
            end else if (led_i !== expected[seen*16 +: 16]) begin
                mismatches++;
                $display("Mismatch at %0t: run %0d n=%0d word %0d expected %h got %h",
                         $time, run_i, switch_i, seen + 1, expected[seen*16 +: 16], led_i);
            end
            seen++;
            led_prev = led_i;
        end
    end

    assign words_seen_o     = seen;
    assign mismatch_count_o = mismatches;
    assign error_count_o    = failures;

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   prog_en_i,
    input  logic                   prog_we_i,
    input  logic [7:0]             prog_addr_i,
    input  logic [`XLEN-1:0]       prog_data_i,
    input  logic [11:0]            switch_i,
    output logic [15:0]            led_o
);

    // ------------------------------------------------------------------------
    // datapath nets
    // ------------------------------------------------------------------------
    cpu_pkg::instr_u  instr;
    cpu_pkg::ctrl_s   ctrl;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] load_data;
    logic             take_branch;

    // alu to memory-or-io
    mem_bus_if bus_if ();

    ifetch u_ifetch (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .prog_en_i     (prog_en_i),
        .prog_we_i     (prog_we_i),
        .prog_addr_i   (prog_addr_i),
        .prog_data_i   (prog_data_i),
        .take_branch_i (take_branch),
        .jump_i        (ctrl.jump),
        .imm_i         (imm),
        .instr_o       (instr),
        .pc_plus4_o    (pc_plus4),
        .pc_o          (pc)
    );

    decoder u_decoder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr),
        .pc_plus4_i   (pc_plus4),
        .alu_result_i (alu_result),
        .load_data_i  (load_data),
        .ctrl_o       (ctrl),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .imm_o        (imm)
    );

    alu u_alu (
        .ctrl_i        (ctrl),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .imm_i         (imm),
        .pc_i          (pc),
        .result_o      (alu_result),
        .take_branch_o (take_branch),
        .bus           (bus_if.datapath)
    );

    mem_or_io u_mem_or_io (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bus         (bus_if.memory),
        .switch_i    (switch_i),
        .load_data_o (load_data),
        .led_o       (led_o)
    );

endmodule

// ==== verilog/mem_or_io.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module mem_or_io (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    mem_bus_if.memory              bus,
    input  logic [11:0]            switch_i,
    output logic [`XLEN-1:0]       load_data_o,
    output logic [15:0]            led_o
);

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    io_pkg::region_e    region;
    logic [`XLEN-1:0]   dmem [`DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [15:0]        led_q;

    assign word_idx = bus.addr[DMEM_AW+1:2];

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------
    always_comb begin
        if (bus.addr >= `IO_BASE) begin
            if (bus.addr == `IO_SWITCH_ADDR) begin
                region = io_pkg::region_switch;
            end else if (bus.addr == `IO_LED_ADDR) begin
                region = io_pkg::region_led;
            end else begin
                region = io_pkg::region_none;
            end
        end else if (bus.addr[`XLEN-1:DMEM_AW+2] == '0) begin
            region = io_pkg::region_dmem;
        end else begin
            // gap between data memory and io
            region = io_pkg::region_none;
        end
    end

    // read path, switches zero-extended
    always_comb begin
        bus.rdata = '0;
        if (bus.rd) begin
            case (region)
                io_pkg::region_dmem:   bus.rdata = dmem[word_idx];
                io_pkg::region_switch: bus.rdata = {{(`XLEN-12){1'b0}}, switch_i};
                default:               bus.rdata = '0;
            endcase
        end
    end

    assign load_data_o = bus.rdata;

    // ------------------------------------------------------------------------
    // write path
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (bus.wr && region == io_pkg::region_dmem) begin
            dmem[word_idx] <= bus.wdata;
        end
    end

    // led register, low half of the store
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            led_q <= '0;
        end else if (bus.wr && region == io_pkg::region_led) begin
            led_q <= bus.wdata[15:0];
        end
    end

    assign led_o = led_q;

    // decode upstream must never ask for both
    a_rd_wr_excl : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(bus.rd && bus.wr)
    );

    // switches are input only
    a_no_switch_write : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) bus.wr |-> (region != io_pkg::region_switch)
    );

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module alu (
    input  cpu_pkg::ctrl_s         ctrl_i,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    input  logic [`XLEN-1:0]       imm_i,
    input  logic [`XLEN-1:0]       pc_i,
    output logic [`XLEN-1:0]       result_o,
    output logic                   take_branch_o,
    mem_bus_if.datapath            bus
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic             is_zero;

    // jal puts its target on the result, rs1 otherwise
    assign op_a = ctrl_i.jump ? pc_i : rs1_data_i;
    assign op_b = ctrl_i.alu_src_imm ? imm_i : rs2_data_i;

    always_comb begin
        case (ctrl_i.alu_op)
            cpu_pkg::alu_add:    result_o = op_a + op_b;
            cpu_pkg::alu_sub:    result_o = op_a - op_b;
            cpu_pkg::alu_and:    result_o = op_a & op_b;
            cpu_pkg::alu_or:     result_o = op_a | op_b;
            cpu_pkg::alu_xor:    result_o = op_a ^ op_b;
            cpu_pkg::alu_slt: begin
                result_o = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            // lui
            cpu_pkg::alu_pass_b: result_o = op_b;
            default:             result_o = '0;
        endcase
    end

    // branches subtract, so zero means equal
    assign is_zero       = (result_o == '0);
    assign take_branch_o = ctrl_i.branch && (is_zero ^ ctrl_i.branch_ne);

    // load/store request
    assign bus.addr  = result_o;
    assign bus.wdata = rs2_data_i;
    assign bus.rd    = ctrl_i.mem_read;
    assign bus.wr    = ctrl_i.mem_write;

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module decoder (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  cpu_pkg::instr_u        instr_i,
    input  logic [`XLEN-1:0]       pc_plus4_i,
    input  logic [`XLEN-1:0]       alu_result_i,
    input  logic [`XLEN-1:0]       load_data_i,
    output cpu_pkg::ctrl_s         ctrl_o,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    output logic [`XLEN-1:0]       imm_o
);

    logic [`XLEN-1:0] regs [32];
    logic [`XLEN-1:0] wb_data;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [4:0]       rd_addr;

    // register fields sit at the same bits in every view
    assign rs1_addr = instr_i.r_fmt.rs1;
    assign rs2_addr = instr_i.s_fmt.rs2;
    assign rd_addr  = instr_i.i_fmt.rd;

    // ------------------------------------------------------------------------
    // control and immediate
    // ------------------------------------------------------------------------
    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = cpu_pkg::alu_add;
        imm_o         = '0;
        case (instr_i.i_fmt.opcode)
            `OP_RTYPE: begin
                ctrl_o.reg_write = 1'b1;
                case (instr_i.r_fmt.funct3)
                    3'b000: begin
                        // funct7 bit 5 splits add from sub
                        ctrl_o.alu_op = instr_i.r_fmt.funct7[5] ? cpu_pkg::alu_sub
                                                                : cpu_pkg::alu_add;
                    end
                    3'b010:  ctrl_o.alu_op = cpu_pkg::alu_slt;
                    3'b100:  ctrl_o.alu_op = cpu_pkg::alu_xor;
                    3'b110:  ctrl_o.alu_op = cpu_pkg::alu_or;
                    3'b111:  ctrl_o.alu_op = cpu_pkg::alu_and;
                    default: ctrl_o.alu_op = cpu_pkg::alu_add;
                endcase
            end
            `OP_ITYPE: begin
                // addi only
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                imm_o = {{20{instr_i.i_fmt.imm_11_0[11]}}, instr_i.i_fmt.imm_11_0};
            end
            `OP_LOAD: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_read    = 1'b1;
                ctrl_o.mem_to_reg  = 1'b1;
                imm_o = {{20{instr_i.i_fmt.imm_11_0[11]}}, instr_i.i_fmt.imm_11_0};
            end
            `OP_STORE: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_write   = 1'b1;
                imm_o = {{20{instr_i.s_fmt.imm_11_5[6]}},
                         instr_i.s_fmt.imm_11_5, instr_i.s_fmt.imm_4_0};
            end
            `OP_BRANCH: begin
                // compare by subtraction
                // funct3 bit 0 picks bne
                ctrl_o.branch    = 1'b1;
                ctrl_o.branch_ne = instr_i.b_fmt.funct3[0];
                ctrl_o.alu_op    = cpu_pkg::alu_sub;
                imm_o = {{19{instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_12,
                         instr_i.b_fmt.imm_11, instr_i.b_fmt.imm_10_5,
                         instr_i.b_fmt.imm_4_1, 1'b0};
            end
            `OP_LUI: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = cpu_pkg::alu_pass_b;
                // word bits 31:12 read back in order through the j view
                imm_o = {instr_i.j_fmt.imm_20, instr_i.j_fmt.imm_10_1,
                         instr_i.j_fmt.imm_11, instr_i.j_fmt.imm_19_12, 12'b0};
            end
            `OP_JAL: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.jump        = 1'b1;
                // pc plus offset through the alu
                ctrl_o.alu_src_imm = 1'b1;
                imm_o = {{11{instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_20,
                         instr_i.j_fmt.imm_19_12, instr_i.j_fmt.imm_11,
                         instr_i.j_fmt.imm_10_1, 1'b0};
            end
            default: begin
                // nothing retires for an unsupported opcode
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // register file
    // ------------------------------------------------------------------------
    // load data over the jal link over the alu result
    assign wb_data = ctrl_o.mem_to_reg ? load_data_i :
                     ctrl_o.jump       ? pc_plus4_i  : alu_result_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl_o.reg_write && rd_addr != 5'd0) begin
            regs[rd_addr] <= wb_data;
        end
    end

    assign rs1_data_o = regs[rs1_addr];
    assign rs2_data_o = regs[rs2_addr];

    // x0 stays zero through reset and the dropped writes
    a_x0_zero : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) (rs1_addr == 5'd0) |-> (rs1_data_o == '0)
    );

endmodule

// ==== verilog/ifetch.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module ifetch (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   prog_en_i,
    input  logic                   prog_we_i,
    input  logic [7:0]             prog_addr_i,
    input  logic [`XLEN-1:0]       prog_data_i,
    input  logic                   take_branch_i,
    input  logic                   jump_i,
    input  logic [`XLEN-1:0]       imm_i,
    output cpu_pkg::instr_u        instr_o,
    output logic [`XLEN-1:0]       pc_plus4_o,
    output logic [`XLEN-1:0]       pc_o
);

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] imem [`IMEM_WORDS];
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;

    // ------------------------------------------------------------------------
    // program load port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (prog_we_i) begin
            imem[prog_addr_i[IMEM_AW-1:0]] <= prog_data_i;
        end
    end

    // all-zero opcode decodes to nothing, so no retire while loading
    assign instr_o    = prog_en_i ? '0 : imem[pc_q[IMEM_AW+1:2]];
    assign pc_plus4_o = pc_q + `XLEN'd4;
    assign pc_o       = pc_q;

    // taken branch and jal are both pc relative
    assign pc_next = (take_branch_i || jump_i) ? pc_q + imm_i : pc_plus4_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (prog_en_i) begin
            // parked at zero until loading ends
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // decoded offsets have to keep the pc on a word
    a_pc_aligned : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) pc_q[1:0] == 2'b00
    );

endmodule

// ==== verilog/mem_bus_if.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

// load/store request, datapath to memory-or-io
// rd and wr are never both high
// rdata follows addr combinationally while rd is high, zero otherwise
// a write lands on the clk_i edge closing the instruction
// the memory side maps addr onto io_pkg::region_e
interface mem_bus_if;
    // byte address, straight from the alu result
    logic [`XLEN-1:0] addr;
    // store data, register rs2
    logic [`XLEN-1:0] wdata;
    logic             rd;
    logic             wr;
    logic [`XLEN-1:0] rdata;

    modport datapath (
        output addr,
        output wdata,
        output rd,
        output wr,
        input  rdata
    );

    modport memory (
        input  addr,
        input  wdata,
        input  rd,
        input  wr,
        output rdata
    );
endinterface

// ==== verilog/io_pkg.sv ====
package io_pkg;

    // ------------------------------------------------------------------------
    // target of a load or store
    // ------------------------------------------------------------------------
    // dmem   : below IO_BASE and inside data memory
    // switch : the switch word, read only
    // led    : the led register, write only
    // none   : unmapped, reads zero and drops writes
    typedef enum logic [1:0] {
        region_dmem   = 2'd0,
        region_switch = 2'd1,
        region_led    = 2'd2,
        region_none   = 2'd3
    } region_e;

endpackage

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    // ------------------------------------------------------------------------
    // instruction formats, msb first
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_s;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_s;

    // u-type upper bits share this layout, see decoder
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_s;

    // one fetched word, several readings of it
    typedef union packed {
        r_fmt_s r_fmt;
        i_fmt_s i_fmt;
        s_fmt_s s_fmt;
        b_fmt_s b_fmt;
        j_fmt_s j_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_pass_b = 4'd6
    } alu_op_e;

    // decoded control for one instruction
    typedef struct packed {
        logic    reg_write;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    branch;
        // bne when set, beq otherwise
        logic    branch_ne;
        logic    jump;
        alu_op_e alu_op;
    } ctrl_s;

endpackage

// ==== include/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and instruction width
`define XLEN 32

// memory depths, in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// ---------------------------------------------------------------------------
// io map
// ---------------------------------------------------------------------------
// everything at or above IO_BASE is steered away from data memory
`define IO_BASE        32'h0000_f000
`define IO_SWITCH_ADDR 32'h0000_f000
`define IO_LED_ADDR    32'h0000_f004

// opcodes of the supported subset
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_LUI    7'b0110111
`define OP_JAL    7'b1101111

`endif
